/* design/host_req_pkg.sv */
// Host request types, submission queue sizing and stream classification helpers
package host_req_pkg;

    // Submission queue sizing
    localparam int SQ_DEPTH     = 8;
    localparam int SQ_ADDR_BITS = 3;

    // Stream class of a descriptor
    // Card and host stay on the shell, TCP and RDMA leave through the network stack
    typedef enum logic [1:0] {
        STRM_CARD = 2'd0,
        STRM_HOST = 2'd1,
        STRM_TCP  = 2'd2,
        STRM_RDMA = 2'd3
    } strm_t;

    // Single descriptor, 87 bits
    typedef struct packed {
        logic        actv;
        strm_t       strm;
        logic [47:0] vaddr;
        logic [27:0] len;
        logic [7:0]  tag;
    } req_t;

    // Dual request as posted by the host
    // req_1 is the read side, req_2 the write side
    typedef struct packed {
        req_t req_1;
        req_t req_2;
    } dreq_t;

    // Slice widths for the register stages
    localparam int REQ_BITS  = $bits(req_t);
    localparam int DREQ_BITS = $bits(dreq_t);

    // True for streams served by the local engines
    function automatic logic is_strm_local(input strm_t strm);
        logic local_strm;
        case (strm)
            STRM_CARD: local_strm = 1'b1;
            STRM_HOST: local_strm = 1'b1;
            STRM_TCP:  local_strm = 1'b0;
            STRM_RDMA: local_strm = 1'b0;
            default:   local_strm = 1'b0;
        endcase
        return local_strm;
    endfunction

endpackage

/* design/meta_reg.sv */
// Valid/ready register slice with skid entry, registered ready and full throughput
module meta_reg #(
    parameter int DATA_BITS = 87
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 s_valid,
    input  logic [DATA_BITS-1:0] s_data,
    output logic                 s_ready,
    output logic                 m_valid,
    output logic [DATA_BITS-1:0] m_data,
    input  logic                 m_ready
);

    // Second entry catches the beat accepted while the output stalls
    logic                 skid_valid;
    logic [DATA_BITS-1:0] skid_data;
    logic                 out_free;

    // Output register can take a new beat this cycle
    assign out_free = !m_valid || m_ready;

    // Ready comes straight from a flop
    assign s_ready = !skid_valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // Skid drains first to keep order
            if (skid_valid) begin
                m_valid    <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                m_valid <= s_valid;
            end
        end else if (s_valid && s_ready) begin
            skid_valid <= 1'b1;
        end
    end

    // Payload path
    always_ff @(posedge aclk) begin
        if (out_free) begin
            m_data <= skid_valid ? skid_data : s_data;
        end
        if (!out_free && s_ready) begin
            skid_data <= s_data;
        end
    end

    // Stalled beat must not change under the consumer
    a_hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

/* design/sq_fifo.sv */
// Submission queue of dual requests with a registered output stage
module sq_fifo (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                in_valid,
    input  host_req_pkg::dreq_t in_data,
    output logic                in_ready,
    output logic                out_valid,
    output host_req_pkg::dreq_t out_data,
    input  logic                out_ready
);

    // Circular buffer behind the output register
    host_req_pkg::dreq_t mem [host_req_pkg::SQ_DEPTH];

    logic [host_req_pkg::SQ_ADDR_BITS-1:0] wr_ptr;
    logic [host_req_pkg::SQ_ADDR_BITS-1:0] rd_ptr;
    logic [host_req_pkg::SQ_ADDR_BITS:0]   count;

    logic push;
    logic full;
    logic mem_empty;
    logic slot_free;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    assign full      = (count == ($bits(count))'(host_req_pkg::SQ_DEPTH));
    assign mem_empty = (count == '0);
    assign in_ready  = !full;
    assign push      = in_valid && in_ready;

    // Output register empty or being drained
    assign slot_free = !out_valid || out_ready;

    // Empty buffer and free slot let a push land in the output directly
    // This gives one cycle from push to out_valid
    assign bypass = push && mem_empty && slot_free;
    assign mem_wr = push && !bypass;
    assign mem_rd = slot_free && !mem_empty;

    // Pointers, count and output valid
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({mem_wr, mem_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (slot_free) begin
                out_valid <= mem_rd || bypass;
            end
        end
    end

    // Storage and output payload
    always_ff @(posedge aclk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= in_data;
        end
        if (slot_free) begin
            out_data <= bypass ? in_data : mem[rd_ptr];
        end
    end

    // Pointers equal with a nonzero count means the buffer is full
    a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_wr |-> (wr_ptr != rd_ptr) || mem_empty);

    // Pointers equal with a count below depth means the buffer is empty
    a_no_pop_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_rd |-> (wr_ptr != rd_ptr) || full);

endmodule

/* design/host_req_mux.sv */
// Request splitter routing dual requests to local and remote read and write paths
module host_req_mux (
    input  logic                aclk,
    input  logic                aresetn,

    // Submission side
    input  logic                sq_valid,
    input  host_req_pkg::dreq_t sq_data,
    output logic                sq_ready,

    // Local read engine
    output logic                local_rd_valid,
    output host_req_pkg::req_t  local_rd_data,
    input  logic                local_rd_ready,

    // Local write engine
    output logic                local_wr_valid,
    output host_req_pkg::req_t  local_wr_data,
    input  logic                local_wr_ready,

    // Remote read path
    output logic                remote_rd_valid,
    output host_req_pkg::dreq_t remote_rd_data,
    input  logic                remote_rd_ready,

    // Remote write path
    output logic                remote_wr_valid,
    output host_req_pkg::dreq_t remote_wr_data,
    input  logic                remote_wr_ready
);

    // Stream class of each descriptor
    logic remote_strm_1;
    logic remote_strm_2;

    // Request kind from the active bits
    logic both_actv;
    logic rd_only;
    logic wr_only;

    // Remote write that also needs a local read of the source
    logic wr_split;

    // Halves of a split request already accepted
    logic remote_wr_taken;
    logic local_rd_taken;

    assign remote_strm_1 = !host_req_pkg::is_strm_local(sq_data.req_1.strm);
    assign remote_strm_2 = !host_req_pkg::is_strm_local(sq_data.req_2.strm);

    assign both_actv = sq_data.req_1.actv && sq_data.req_2.actv;
    assign rd_only   = sq_data.req_1.actv && !sq_data.req_2.actv;
    assign wr_only   = !sq_data.req_1.actv && sq_data.req_2.actv;
    assign wr_split  = sq_valid && wr_only && remote_strm_2;

    // Outgoing payloads with rewritten active bits
    always_comb begin
        local_rd_data      = sq_data.req_1;
        local_rd_data.actv = 1'b1;
        local_wr_data      = sq_data.req_2;
        local_wr_data.actv = 1'b1;

        remote_rd_data            = sq_data;
        remote_rd_data.req_1.actv = 1'b1;
        remote_rd_data.req_2.actv = 1'b0;
        remote_wr_data            = sq_data;
        remote_wr_data.req_1.actv = 1'b0;
        remote_wr_data.req_2.actv = 1'b1;
    end

    // Routing and upstream ready
    always_comb begin
        sq_ready        = 1'b0;
        local_rd_valid  = 1'b0;
        local_wr_valid  = 1'b0;
        remote_rd_valid = 1'b0;
        remote_wr_valid = 1'b0;

        if (sq_valid) begin
            if (both_actv) begin
                // Local copy goes out on both engines in one cycle
                sq_ready       = local_rd_ready && local_wr_ready;
                local_rd_valid = sq_ready;
                local_wr_valid = sq_ready;
            end else if (rd_only) begin
                sq_ready        = remote_strm_1 ? remote_rd_ready : local_rd_ready;
                remote_rd_valid = remote_strm_1;
                local_rd_valid  = !remote_strm_1;
            end else if (wr_only) begin
                if (remote_strm_2) begin
                    // Each half may go in its own cycle
                    remote_wr_valid = !remote_wr_taken;
                    local_rd_valid  = !local_rd_taken;
                    sq_ready        = (remote_wr_taken || remote_wr_ready) &&
                                      (local_rd_taken || local_rd_ready);
                end else begin
                    local_wr_valid = 1'b1;
                    sq_ready       = local_wr_ready;
                end
            end else begin
                // Nothing active so drop it
                sq_ready = 1'b1;
            end
        end
    end

    // Split request bookkeeping
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            remote_wr_taken <= 1'b0;
            local_rd_taken  <= 1'b0;
        end else if (sq_valid && sq_ready) begin
            // Request consumed so start clean
            remote_wr_taken <= 1'b0;
            local_rd_taken  <= 1'b0;
        end else if (wr_split) begin
            if (remote_wr_valid && remote_wr_ready) begin
                remote_wr_taken <= 1'b1;
            end
            if (local_rd_valid && local_rd_ready) begin
                local_rd_taken <= 1'b1;
            end
        end
    end

    // Second half always completes the request in the same cycle
    a_flags_exclusive: assert property (@(posedge aclk) disable iff (!aresetn)
        !(remote_wr_taken && local_rd_taken));

    // Upstream slice holds the request while half of it is out
    a_hold_split: assert property (@(posedge aclk) disable iff (!aresetn)
        (remote_wr_taken || local_rd_taken) |-> sq_valid && wr_only && remote_strm_2);

endmodule

/* design/host_req_top.sv */
// Host request path top with submission queue, splitter and register slices
module host_req_top (
    input  logic                aclk,
    input  logic                aresetn,

    // Host submission queue
    input  logic                sq_valid,
    input  host_req_pkg::dreq_t sq_data,
    output logic                sq_ready,

    // Local read engine
    output logic                local_rd_valid,
    output host_req_pkg::req_t  local_rd_data,
    input  logic                local_rd_ready,

    // Local write engine
    output logic                local_wr_valid,
    output host_req_pkg::req_t  local_wr_data,
    input  logic                local_wr_ready,

    // Remote read path
    output logic                remote_rd_valid,
    output host_req_pkg::dreq_t remote_rd_data,
    input  logic                remote_rd_ready,

    // Remote write path
    output logic                remote_wr_valid,
    output host_req_pkg::dreq_t remote_wr_data,
    input  logic                remote_wr_ready
);

    // Queue to input slice
    logic                fifo_valid;
    host_req_pkg::dreq_t fifo_data;
    logic                fifo_ready;

    // Input slice to splitter
    logic                mux_valid;
    host_req_pkg::dreq_t mux_data;
    logic                mux_ready;

    // Splitter to output slices
    logic                lrd_valid;
    host_req_pkg::req_t  lrd_data;
    logic                lrd_ready;
    logic                lwr_valid;
    host_req_pkg::req_t  lwr_data;
    logic                lwr_ready;
    logic                rrd_valid;
    host_req_pkg::dreq_t rrd_data;
    logic                rrd_ready;
    logic                rwr_valid;
    host_req_pkg::dreq_t rwr_data;
    logic                rwr_ready;

    sq_fifo inst_sq_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (sq_valid),
        .in_data   (sq_data),
        .in_ready  (sq_ready),
        .out_valid (fifo_valid),
        .out_data  (fifo_data),
        .out_ready (fifo_ready)
    );

    // Sink slice in front of the splitter
    meta_reg #(.DATA_BITS(host_req_pkg::DREQ_BITS)) inst_reg_sq (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (fifo_valid),
        .s_data  (fifo_data),
        .s_ready (fifo_ready),
        .m_valid (mux_valid),
        .m_data  (mux_data),
        .m_ready (mux_ready)
    );

    host_req_mux inst_mux (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .sq_valid        (mux_valid),
        .sq_data         (mux_data),
        .sq_ready        (mux_ready),
        .local_rd_valid  (lrd_valid),
        .local_rd_data   (lrd_data),
        .local_rd_ready  (lrd_ready),
        .local_wr_valid  (lwr_valid),
        .local_wr_data   (lwr_data),
        .local_wr_ready  (lwr_ready),
        .remote_rd_valid (rrd_valid),
        .remote_rd_data  (rrd_data),
        .remote_rd_ready (rrd_ready),
        .remote_wr_valid (rwr_valid),
        .remote_wr_data  (rwr_data),
        .remote_wr_ready (rwr_ready)
    );

    // Output slices break the ready-to-valid path of the splitter
    meta_reg #(.DATA_BITS(host_req_pkg::REQ_BITS)) inst_reg_local_rd (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (lrd_valid),
        .s_data  (lrd_data),
        .s_ready (lrd_ready),
        .m_valid (local_rd_valid),
        .m_data  (local_rd_data),
        .m_ready (local_rd_ready)
    );

    meta_reg #(.DATA_BITS(host_req_pkg::REQ_BITS)) inst_reg_local_wr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (lwr_valid),
        .s_data  (lwr_data),
        .s_ready (lwr_ready),
        .m_valid (local_wr_valid),
        .m_data  (local_wr_data),
        .m_ready (local_wr_ready)
    );

    meta_reg #(.DATA_BITS(host_req_pkg::DREQ_BITS)) inst_reg_remote_rd (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (rrd_valid),
        .s_data  (rrd_data),
        .s_ready (rrd_ready),
        .m_valid (remote_rd_valid),
        .m_data  (remote_rd_data),
        .m_ready (remote_rd_ready)
    );

    meta_reg #(.DATA_BITS(host_req_pkg::DREQ_BITS)) inst_reg_remote_wr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (rwr_valid),
        .s_data  (rwr_data),
        .s_ready (rwr_ready),
        .m_valid (remote_wr_valid),
        .m_data  (remote_wr_data),
        .m_ready (remote_wr_ready)
    );

endmodule

/* dv/host_req_tb.sv */
// Testbench for the host request splitter with reference model and random back-pressure
module host_req_tb;

    localparam int NUM_TESTS      = 12;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 200;
    localparam int DREQ_BITS      = host_req_pkg::DREQ_BITS;
    localparam int REQ_BITS       = host_req_pkg::REQ_BITS;

    logic                aclk;
    logic                aresetn;
    logic                sq_valid;
    host_req_pkg::dreq_t sq_data;
    logic                sq_ready;
    logic                local_rd_valid;
    host_req_pkg::req_t  local_rd_data;
    logic                local_rd_ready;
    logic                local_wr_valid;
    host_req_pkg::req_t  local_wr_data;
    logic                local_wr_ready;
    logic                remote_rd_valid;
    host_req_pkg::dreq_t remote_rd_data;
    logic                remote_rd_ready;
    logic                remote_wr_valid;
    host_req_pkg::dreq_t remote_wr_data;
    logic                remote_wr_ready;

    // Stimulus table
    host_req_pkg::dreq_t stim [NUM_TESTS];
    string               test_name [NUM_TESTS];

    // Expected items per output port, with the test that produced them
    host_req_pkg::req_t  exp_lrd [$];
    host_req_pkg::req_t  exp_lwr [$];
    host_req_pkg::dreq_t exp_rrd [$];
    host_req_pkg::dreq_t exp_rwr [$];
    string               name_lrd [$];
    string               name_lwr [$];
    string               name_rrd [$];
    string               name_rwr [$];

    // Back-pressure source
    logic        rand_ready;
    logic [31:0] lfsr_state;

    host_req_top dut (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .sq_valid        (sq_valid),
        .sq_data         (sq_data),
        .sq_ready        (sq_ready),
        .local_rd_valid  (local_rd_valid),
        .local_rd_data   (local_rd_data),
        .local_rd_ready  (local_rd_ready),
        .local_wr_valid  (local_wr_valid),
        .local_wr_data   (local_wr_data),
        .local_wr_ready  (local_wr_ready),
        .remote_rd_valid (remote_rd_valid),
        .remote_rd_data  (remote_rd_data),
        .remote_rd_ready (remote_rd_ready),
        .remote_wr_valid (remote_wr_valid),
        .remote_wr_data  (remote_wr_data),
        .remote_wr_ready (remote_wr_ready)
    );

    always #2 aclk = ~aclk;

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic host_req_pkg::req_t make_req(input logic actv,
            input host_req_pkg::strm_t strm, input logic [47:0] vaddr,
            input logic [27:0] len, input logic [7:0] tag);
        host_req_pkg::req_t r;
        r.actv  = actv;
        r.strm  = strm;
        r.vaddr = vaddr;
        r.len   = len;
        r.tag   = tag;
        return r;
    endfunction

    // Zero extend a single descriptor to the compare width
    function automatic logic [DREQ_BITS-1:0] widen_req(input host_req_pkg::req_t r);
        return {{(DREQ_BITS - REQ_BITS){1'b0}}, r};
    endfunction

    function automatic int pending_items();
        return exp_lrd.size() + exp_lwr.size() + exp_rrd.size() + exp_rwr.size();
    endfunction

    task automatic check_value(input string name, input logic [DREQ_BITS-1:0] expected,
            input logic [DREQ_BITS-1:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_unexpected(input string port);
        $display("Unexpected item on %s while nothing was expected there", port);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic set_entry(input int idx, input string name,
            input host_req_pkg::req_t r1, input host_req_pkg::req_t r2);
        test_name[idx]   = name;
        stim[idx].req_1  = r1;
        stim[idx].req_2  = r2;
    endtask

    // Inactive descriptors carry nonzero fields so the active bit rewrite shows up
    task automatic load_table();
        set_entry(0, "rd_local_card",
            make_req(1'b1, host_req_pkg::STRM_CARD, 48'h0000_1000_0040, 28'h40, 8'h01),
            make_req(1'b0, host_req_pkg::STRM_HOST, 48'h0000_dead_0000, 28'h10, 8'h81));
        set_entry(1, "rd_local_host",
            make_req(1'b1, host_req_pkg::STRM_HOST, 48'h7fff_0000_1000, 28'h1000, 8'h02),
            make_req(1'b0, host_req_pkg::STRM_TCP, 48'h0000_0000_0abc, 28'h0, 8'h82));
        set_entry(2, "wr_local_host",
            make_req(1'b0, host_req_pkg::STRM_RDMA, 48'h0000_0000_0123, 28'h5, 8'h83),
            make_req(1'b1, host_req_pkg::STRM_HOST, 48'h0001_2345_6780, 28'h200, 8'h03));
        set_entry(3, "wr_local_card",
            make_req(1'b0, host_req_pkg::STRM_CARD, 48'h0, 28'h0, 8'h84),
            make_req(1'b1, host_req_pkg::STRM_CARD, 48'h0000_0040_0000, 28'h8000, 8'h04));
        set_entry(4, "copy_local",
            make_req(1'b1, host_req_pkg::STRM_HOST, 48'h0000_1111_0000, 28'h100, 8'h05),
            make_req(1'b1, host_req_pkg::STRM_CARD, 48'h0000_2222_0000, 28'h100, 8'h85));
        set_entry(5, "copy_net_strm",
            make_req(1'b1, host_req_pkg::STRM_TCP, 48'h0000_3333_0000, 28'hfff_ffff, 8'h06),
            make_req(1'b1, host_req_pkg::STRM_RDMA, 48'hffff_ffff_ffff, 28'h1, 8'h86));
        set_entry(6, "rd_remote_tcp",
            make_req(1'b1, host_req_pkg::STRM_TCP, 48'h0000_4444_0000, 28'h5dc, 8'h07),
            make_req(1'b0, host_req_pkg::STRM_HOST, 48'h0000_5555_0000, 28'h20, 8'h87));
        set_entry(7, "rd_remote_rdma",
            make_req(1'b1, host_req_pkg::STRM_RDMA, 48'h0000_6666_0000, 28'h800, 8'h08),
            make_req(1'b0, host_req_pkg::STRM_RDMA, 48'h0000_7777_0000, 28'h30, 8'h88));
        set_entry(8, "wr_remote_tcp",
            make_req(1'b0, host_req_pkg::STRM_HOST, 48'h0000_8888_0000, 28'h400, 8'h09),
            make_req(1'b1, host_req_pkg::STRM_TCP, 48'h0000_9999_0000, 28'h400, 8'h89));
        set_entry(9, "none_active",
            make_req(1'b0, host_req_pkg::STRM_CARD, 48'h0000_aaaa_0000, 28'h11, 8'h0a),
            make_req(1'b0, host_req_pkg::STRM_TCP, 48'h0000_bbbb_0000, 28'h22, 8'h8a));
        set_entry(10, "wr_remote_rdma",
            make_req(1'b0, host_req_pkg::STRM_CARD, 48'h0000_cccc_0000, 28'h2000, 8'h0b),
            make_req(1'b1, host_req_pkg::STRM_RDMA, 48'h0000_dddd_0000, 28'h2000, 8'h8b));
        set_entry(11, "rd_local_after_split",
            make_req(1'b1, host_req_pkg::STRM_CARD, 48'h0000_eeee_0000, 28'h80, 8'h0c),
            make_req(1'b0, host_req_pkg::STRM_TCP, 48'h0000_ffff_0000, 28'h90, 8'h8c));
    endtask

    // Reference model of the routing rules
    task automatic predict(input int idx);
        host_req_pkg::dreq_t d;
        host_req_pkg::dreq_t rem;
        host_req_pkg::req_t  rd;
        host_req_pkg::req_t  wr;
        d       = stim[idx];
        rd      = d.req_1;
        rd.actv = 1'b1;
        wr      = d.req_2;
        wr.actv = 1'b1;
        rem     = d;
        if (d.req_1.actv && d.req_2.actv) begin
            // Local copy regardless of stream class
            exp_lrd.push_back(rd);
            name_lrd.push_back(test_name[idx]);
            exp_lwr.push_back(wr);
            name_lwr.push_back(test_name[idx]);
        end else if (d.req_1.actv) begin
            if (host_req_pkg::is_strm_local(d.req_1.strm)) begin
                exp_lrd.push_back(rd);
                name_lrd.push_back(test_name[idx]);
            end else begin
                rem.req_2.actv = 1'b0;
                exp_rrd.push_back(rem);
                name_rrd.push_back(test_name[idx]);
            end
        end else if (d.req_2.actv) begin
            if (host_req_pkg::is_strm_local(d.req_2.strm)) begin
                exp_lwr.push_back(wr);
                name_lwr.push_back(test_name[idx]);
            end else begin
                // Network write plus local fetch of the source data
                rem.req_1.actv = 1'b0;
                exp_rwr.push_back(rem);
                name_rwr.push_back(test_name[idx]);
                exp_lrd.push_back(rd);
                name_lrd.push_back(test_name[idx]);
            end
        end
    endtask

    // Post every table entry, each held until the queue takes it
    task automatic run_table();
        for (int i = 0; i < NUM_TESTS; i++) begin
            sq_valid <= 1'b1;
            sq_data  <= stim[i];
            predict(i);
            do @(posedge aclk); while (!sq_ready);
        end
        sq_valid <= 1'b0;
        sq_data  <= '0;
    endtask

    task automatic wait_drain();
        while (pending_items() != 0) begin
            @(posedge aclk);
        end
        // Room for a stray item to show up
        repeat (16) @(posedge aclk);
    endtask

    // Output readies, all high or one LFSR bit each
    always @(posedge aclk) begin
        if (rand_ready) begin
            lfsr_state = lfsr_step(lfsr_state);
            local_rd_ready <= lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
            local_wr_ready <= lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
            remote_rd_ready <= lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
            remote_wr_ready <= lfsr_state[0];
        end else begin
            local_rd_ready  <= 1'b1;
            local_wr_ready  <= 1'b1;
            remote_rd_ready <= 1'b1;
            remote_wr_ready <= 1'b1;
        end
    end

    // Output monitors
    always @(posedge aclk) begin
        if (aresetn) begin
            if (local_rd_valid && local_rd_ready) begin
                if (exp_lrd.size() == 0) report_unexpected("local_rd");
                else check_value({"local_rd ", name_lrd.pop_front()},
                    widen_req(exp_lrd.pop_front()), widen_req(local_rd_data));
            end
            if (local_wr_valid && local_wr_ready) begin
                if (exp_lwr.size() == 0) report_unexpected("local_wr");
                else check_value({"local_wr ", name_lwr.pop_front()},
                    widen_req(exp_lwr.pop_front()), widen_req(local_wr_data));
            end
            if (remote_rd_valid && remote_rd_ready) begin
                if (exp_rrd.size() == 0) report_unexpected("remote_rd");
                else check_value({"remote_rd ", name_rrd.pop_front()},
                    exp_rrd.pop_front(), remote_rd_data);
            end
            if (remote_wr_valid && remote_wr_ready) begin
                if (exp_rwr.size() == 0) report_unexpected("remote_wr");
                else check_value({"remote_wr ", name_rwr.pop_front()},
                    exp_rwr.pop_front(), remote_wr_data);
            end
        end
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge aclk);
        $display("Timeout after %0d cycles, outputs stopped with %0d items still expected",
            TIMEOUT_CYCLES, pending_items());
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    initial begin
        aclk            = 1'b0;
        aresetn         = 1'b0;
        sq_valid        = 1'b0;
        sq_data         = '0;
        local_rd_ready  = 1'b1;
        local_wr_ready  = 1'b1;
        remote_rd_ready = 1'b1;
        remote_wr_ready = 1'b1;
        rand_ready      = 1'b0;
        lfsr_state      = 32'h5bad6f64;
        load_table();

        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        // Idle outputs and open queue out of reset
        check_value("reset_state", DREQ_BITS'(5'b00001),
            DREQ_BITS'({local_rd_valid, local_wr_valid, remote_rd_valid,
            remote_wr_valid, sq_ready}));

        // Routing with every output always ready
        run_table();
        wait_drain();

        // Same table under random back-pressure on all outputs
        rand_ready <= 1'b1;
        run_table();
        wait_drain();

        if (pending_items() == 0 && !local_rd_valid && !local_wr_valid &&
                !remote_rd_valid && !remote_wr_valid) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Run ended with items missing or an output still valid");
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

/* host_req_top.f */
design/host_req_pkg.sv
design/meta_reg.sv
design/sq_fifo.sv
design/host_req_mux.sv
design/host_req_top.sv
dv/host_req_tb.sv

/* Makefile */
# Verilator build and run of the host request splitter testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= host_req_tb
FILELIST  ?= host_req_top.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
